// File: Bender.yml
package:
  name: biquad

sources:
  # Packages first, then the blocks, then the top level
  - hdl/q_arith_pkg.sv
  - hdl/biquad_pkg.sv
  - hdl/nq_multiplier.sv
  - hdl/nq_accumulator.sv
  - hdl/biquad_delay_line.sv
  - hdl/biquad_sequencer.sv
  - hdl/biquad_top.sv

  - target: test
    files:
      - testbench/biquad_tb.sv

// File: files.f
hdl/q_arith_pkg.sv
hdl/biquad_pkg.sv
hdl/nq_multiplier.sv
hdl/nq_accumulator.sv
hdl/biquad_delay_line.sv
hdl/biquad_sequencer.sv
hdl/biquad_top.sv
testbench/biquad_tb.sv

// File: hdl/biquad_delay_line.sv
// Biquad sample history
module biquad_delay_line (
  input  logic                 clk,
  input  logic                 rst_n,
  input  q_arith_pkg::q_word_t x,
  input  q_arith_pkg::q_word_t y,
  input  logic                 shift,
  input  logic                 sample_load,
  input  biquad_pkg::tap_sel_t tap,
  output q_arith_pkg::q_word_t operand
);

  // Sample under evaluation
  q_arith_pkg::q_word_t x0;

  // Input history
  q_arith_pkg::q_word_t x1;
  q_arith_pkg::q_word_t x2;

  // Output history
  q_arith_pkg::q_word_t y1;
  q_arith_pkg::q_word_t y2;

  //////////////////////////////
  // History registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x0 <= '0;
      x1 <= '0;
      x2 <= '0;
      y1 <= '0;
      y2 <= '0;
    end else begin
      // The sample is captured when the sequencer accepts it
      if (sample_load) begin
        x0 <= x;
      end
      // On a finished result both histories move one step
      if (shift) begin
        x1 <= x0;
        x2 <= x1;
        y1 <= y;
        y2 <= y1;
      end
    end
  end

  // Operand for the tap that is being issued
  always_comb begin
    case (tap)
      biquad_pkg::TAP_X:  operand = x0;
      biquad_pkg::TAP_X1: operand = x1;
      biquad_pkg::TAP_X2: operand = x2;
      biquad_pkg::TAP_Y1: operand = y1;
      biquad_pkg::TAP_Y2: operand = y2;
      default:            operand = '0;
    endcase
  end

endmodule

// File: hdl/biquad_pkg.sv
// Biquad filter section types
package biquad_pkg;

  //////////////////////////////
  // Coefficients
  //////////////////////////////

  // Full coefficient set of one section that is loaded in a single write
  // b0 sits in the top word, a2 in the bottom word
  typedef struct packed {
    q_arith_pkg::q_word_t b0;
    q_arith_pkg::q_word_t b1;
    q_arith_pkg::q_word_t b2;
    q_arith_pkg::q_word_t a1;
    q_arith_pkg::q_word_t a2;
  } biquad_coef_t;

  //////////////////////////////
  // Control encodings
  //////////////////////////////

  // Tap under evaluation that selects the history word and its coefficient
  typedef enum logic [2:0] {
    TAP_X  = 3'd0,
    TAP_X1 = 3'd1,
    TAP_X2 = 3'd2,
    TAP_Y1 = 3'd3,
    TAP_Y2 = 3'd4
  } tap_sel_t;

  // Accumulator opcodes
  typedef enum logic [1:0] {
    ACC_HOLD = 2'd0,
    ACC_LOAD = 2'd1,
    ACC_ADD  = 2'd2,
    ACC_SUB  = 2'd3
  } acc_op_t;

  // Sequencer states
  typedef enum logic [1:0] {
    S_IDLE  = 2'd0,
    S_ISSUE = 2'd1,
    S_DRAIN = 2'd2,
    S_DONE  = 2'd3
  } seq_state_t;

endpackage

// File: hdl/biquad_sequencer.sv
// Biquad tap sequencer
module biquad_sequencer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 x_valid,
  output biquad_pkg::tap_sel_t tap,
  output biquad_pkg::acc_op_t  acc_op,
  output logic                 shift,
  output logic                 sample_load,
  output logic                 busy,
  output logic                 y_valid
);

  // FSM state
  biquad_pkg::seq_state_t state;
  biquad_pkg::seq_state_t state_next;

  // Tap being issued to the multiplier
  biquad_pkg::tap_sel_t   tap_q;
  biquad_pkg::tap_sel_t   tap_next;

  // Opcode for the product that arrives in the next cycle
  biquad_pkg::acc_op_t    op_q;

  // Tap order X, X1, X2, Y1, Y2
  function automatic biquad_pkg::tap_sel_t next_tap(input biquad_pkg::tap_sel_t t);
    case (t)
      biquad_pkg::TAP_X:  next_tap = biquad_pkg::TAP_X1;
      biquad_pkg::TAP_X1: next_tap = biquad_pkg::TAP_X2;
      biquad_pkg::TAP_X2: next_tap = biquad_pkg::TAP_Y1;
      biquad_pkg::TAP_Y1: next_tap = biquad_pkg::TAP_Y2;
      default:            next_tap = biquad_pkg::TAP_X;
    endcase
  endfunction

  // The first product starts the sum, feed-forward taps add and feedback taps subtract
  function automatic biquad_pkg::acc_op_t tap_op(input biquad_pkg::tap_sel_t t);
    case (t)
      biquad_pkg::TAP_X:  tap_op = biquad_pkg::ACC_LOAD;
      biquad_pkg::TAP_X1: tap_op = biquad_pkg::ACC_ADD;
      biquad_pkg::TAP_X2: tap_op = biquad_pkg::ACC_ADD;
      biquad_pkg::TAP_Y1: tap_op = biquad_pkg::ACC_SUB;
      biquad_pkg::TAP_Y2: tap_op = biquad_pkg::ACC_SUB;
      default:            tap_op = biquad_pkg::ACC_HOLD;
    endcase
  endfunction

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_next = state;
    tap_next   = tap_q;
    case (state)
      biquad_pkg::S_IDLE: begin
        if (x_valid) begin
          state_next = biquad_pkg::S_ISSUE;
          tap_next   = biquad_pkg::TAP_X;
        end
      end
      biquad_pkg::S_ISSUE: begin
        // Five taps are issued, one per cycle
        if (tap_q == biquad_pkg::TAP_Y2) begin
          state_next = biquad_pkg::S_DRAIN;
        end else begin
          tap_next = next_tap(tap_q);
        end
      end
      biquad_pkg::S_DRAIN: begin
        // Last product is accumulated here
        state_next = biquad_pkg::S_DONE;
      end
      biquad_pkg::S_DONE: begin
        state_next = biquad_pkg::S_IDLE;
        tap_next   = biquad_pkg::TAP_X;
      end
      default: begin
        state_next = biquad_pkg::S_IDLE;
        tap_next   = biquad_pkg::TAP_X;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= biquad_pkg::S_IDLE;
      tap_q <= biquad_pkg::TAP_X;
      op_q  <= biquad_pkg::ACC_HOLD;
    end else begin
      state <= state_next;
      tap_q <= tap_next;
      // Opcodes trail the taps by the multiplier latency
      op_q  <= (state == biquad_pkg::S_ISSUE) ? tap_op(tap_q) : biquad_pkg::ACC_HOLD;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign tap         = tap_q;
  assign acc_op      = op_q;
  assign sample_load = (state == biquad_pkg::S_IDLE) && x_valid;
  assign busy        = (state != biquad_pkg::S_IDLE);

  // The result is complete and the history advances in the same cycle
  assign y_valid     = (state == biquad_pkg::S_DONE);
  assign shift       = (state == biquad_pkg::S_DONE);

endmodule

// File: hdl/biquad_top.sv
// Biquad filter section
module biquad_top #(
  // Fractional bits of samples and coefficients
  parameter int Q_BITS = 14
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     coef_wr,
  input  biquad_pkg::biquad_coef_t coef,
  input  logic                     x_valid,
  input  q_arith_pkg::q_word_t     x,
  output q_arith_pkg::q_word_t     y,
  output logic                     y_valid,
  output logic                     overflow,
  output logic                     busy
);

  // Active coefficient set
  biquad_pkg::biquad_coef_t coef_q;

  // Sequencer controls
  biquad_pkg::tap_sel_t     tap;
  biquad_pkg::acc_op_t      acc_op;
  logic                     shift;
  logic                     sample_load;

  // Datapath
  q_arith_pkg::q_word_t     operand;
  q_arith_pkg::q_word_t     coef_sel;
  q_arith_pkg::q_result_t   product;
  q_arith_pkg::q_result_t   acc;

  //////////////////////////////
  // Coefficients
  //////////////////////////////

  // A write lands at once, even in the middle of a computation
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      coef_q <= '0;
    end else if (coef_wr) begin
      coef_q <= coef;
    end
  end

  // Coefficient for the issued tap
  always_comb begin
    case (tap)
      biquad_pkg::TAP_X:  coef_sel = coef_q.b0;
      biquad_pkg::TAP_X1: coef_sel = coef_q.b1;
      biquad_pkg::TAP_X2: coef_sel = coef_q.b2;
      biquad_pkg::TAP_Y1: coef_sel = coef_q.a1;
      biquad_pkg::TAP_Y2: coef_sel = coef_q.a2;
      default:            coef_sel = '0;
    endcase
  end

  //////////////////////////////
  // Blocks
  //////////////////////////////

  biquad_sequencer seq_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .x_valid     (x_valid),
    .tap         (tap),
    .acc_op      (acc_op),
    .shift       (shift),
    .sample_load (sample_load),
    .busy        (busy),
    .y_valid     (y_valid)
  );

  // History is fed back from the accumulator value
  biquad_delay_line delay_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .x           (x),
    .y           (acc.value),
    .shift       (shift),
    .sample_load (sample_load),
    .tap         (tap),
    .operand     (operand)
  );

  nq_multiplier #(
    .Q_BITS (Q_BITS)
  ) mult_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .multiplicand (operand),
    .multiplier   (coef_sel),
    .product      (product)
  );

  nq_accumulator acc_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .op      (acc_op),
    .product (product),
    .acc     (acc)
  );

  // The accumulator keeps the last result until the next load
  assign y        = acc.value;
  assign overflow = acc.overflow;

endmodule

// File: hdl/nq_accumulator.sv
// Q-word accumulator with sticky overflow
module nq_accumulator (
  input  logic                   clk,
  input  logic                   rst_n,
  input  biquad_pkg::acc_op_t    op,
  input  q_arith_pkg::q_result_t product,
  output q_arith_pkg::q_result_t acc
);

  // Wrapped sum and difference of the running value and the product
  q_arith_pkg::q_word_t sum;
  q_arith_pkg::q_word_t diff;

  // Signed overflow of the add and of the subtract
  logic                 add_ovf;
  logic                 sub_ovf;

  // Sign bits of the operands and of the results
  logic                 acc_sign;
  logic                 prod_sign;

  assign acc_sign  = acc.value[q_arith_pkg::WORD_BITS-1];
  assign prod_sign = product.value[q_arith_pkg::WORD_BITS-1];

  // Two's-complement wrap-around at the word width
  assign sum  = acc.value + product.value;
  assign diff = acc.value - product.value;

  // Adding two words of equal sign must not flip the sign
  assign add_ovf = (acc_sign == prod_sign) &&
                   (sum[q_arith_pkg::WORD_BITS-1] != acc_sign);

  // Subtracting a word of opposite sign must not flip the sign of the minuend
  assign sub_ovf = (acc_sign != prod_sign) &&
                   (diff[q_arith_pkg::WORD_BITS-1] != acc_sign);

  //////////////////////////////
  // Running value
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc <= '0;
    end else begin
      case (op)
        biquad_pkg::ACC_LOAD: begin
          // A load starts a new sum and clears the sticky flag
          acc.value    <= product.value;
          acc.overflow <= product.overflow;
        end
        biquad_pkg::ACC_ADD: begin
          acc.value    <= sum;
          acc.overflow <= acc.overflow | product.overflow | add_ovf;
        end
        biquad_pkg::ACC_SUB: begin
          acc.value    <= diff;
          acc.overflow <= acc.overflow | product.overflow | sub_ovf;
        end
        default: begin
          // Hold keeps both value and flag
          acc <= acc;
        end
      endcase
    end
  end

endmodule

// File: hdl/nq_multiplier.sv
// Registered Q-format multiplier
module nq_multiplier #(
  // Number of fractional bits, must be below the word width
  parameter int Q_BITS = 14
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  q_arith_pkg::q_word_t   multiplicand,
  input  q_arith_pkg::q_word_t   multiplier,
  output q_arith_pkg::q_result_t product
);

  localparam int W = q_arith_pkg::WORD_BITS;

  // Number of product bits that lie above the kept slice
  localparam int UPPER_BITS = W - Q_BITS;

  // Exact double-width signed product
  logic signed [2*W-1:0]   full_product;

  // Bits that are discarded above the kept word
  logic [UPPER_BITS-1:0]   upper_bits;

  // Overflow by the sign rule
  logic                    upper_ovf;

  // Both operands are signed, so the product is sign extended to 2*W bits
  assign full_product = multiplicand * multiplier;

  assign upper_bits = full_product[2*W-1 : W+Q_BITS];

  // Every discarded upper bit must repeat the sign of the exact product
  assign upper_ovf = (upper_bits != {UPPER_BITS{full_product[2*W-1]}});

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      product <= '0;
    end else begin
      // Keep one word starting at the binary point, truncating the fraction
      product.value    <= full_product[W-1+Q_BITS : Q_BITS];
      product.overflow <= upper_ovf;
    end
  end

endmodule

// File: hdl/q_arith_pkg.sv
// Q-format arithmetic types
package q_arith_pkg;

  //////////////////////////////
  // Word format
  //////////////////////////////

  // Width of every sample, coefficient and accumulator word
  parameter int WORD_BITS = 16;

  // One signed fixed-point word
  // The binary point position is set by the Q_BITS parameter of the users
  typedef logic signed [WORD_BITS-1:0] q_word_t;

  //////////////////////////////
  // Arithmetic result
  //////////////////////////////

  // Value of an arithmetic block together with its overflow flag
  // The multiplier and the accumulator both produce this
  typedef struct packed {
    // Truncated or wrapped result word
    q_word_t value;
    // High when the value does not represent the exact result
    logic    overflow;
  } q_result_t;

endpackage

// File: testbench/biquad_tb.sv
// Biquad filter testbench
module biquad_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int Q_BITS     = 14;
  localparam int W          = q_arith_pkg::WORD_BITS;
  localparam int ONE        = 1 << Q_BITS;
  localparam int WORD_MAX   = (1 << (W - 1)) - 1;
  localparam int WORD_MIN   = -(1 << (W - 1));
  localparam int LATENCY    = 7;
  localparam int TIMEOUT    = 20;
  localparam int NUM_ROWS   = 6;
  localparam int ROW_LEN    = 8;
  localparam int RANDOM_LEN = 32;

  logic                     clk;
  logic                     rst_n;
  logic                     coef_wr;
  biquad_pkg::biquad_coef_t coef;
  logic                     x_valid;
  q_arith_pkg::q_word_t     x;
  q_arith_pkg::q_word_t     y;
  logic                     y_valid;
  logic                     overflow;
  logic                     busy;

  // Stimulus table with the first sample of a row in the top word
  biquad_pkg::biquad_coef_t              row_coef [NUM_ROWS];
  q_arith_pkg::q_word_t [ROW_LEN-1:0]    row_x    [NUM_ROWS];
  string                                 row_name [NUM_ROWS];

  // Model copy of the coefficients and the filter history
  biquad_pkg::biquad_coef_t active_coef;
  q_arith_pkg::q_word_t     hist_x1;
  q_arith_pkg::q_word_t     hist_x2;
  q_arith_pkg::q_word_t     hist_y1;
  q_arith_pkg::q_word_t     hist_y2;

  string       test_name;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  bit          timed_out;
  logic [31:0] rng_state;

  biquad_top #(
    .Q_BITS (Q_BITS)
  ) dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .coef_wr  (coef_wr),
    .coef     (coef),
    .x_valid  (x_valid),
    .x        (x),
    .y        (y),
    .y_valid  (y_valid),
    .overflow (overflow),
    .busy     (busy)
  );

  always #20 clk = ~clk;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic biquad_pkg::biquad_coef_t make_coef(input int b0, input int b1,
                                                         input int b2, input int a1,
                                                         input int a2);
    biquad_pkg::biquad_coef_t c;
    c.b0 = b0[W-1:0];
    c.b1 = b1[W-1:0];
    c.b2 = b2[W-1:0];
    c.a1 = a1[W-1:0];
    c.a2 = a2[W-1:0];
    return c;
  endfunction

  // Product truncated to the word at the binary point
  // Overflow when the exact product shifted down by Q_BITS does not sign extend from bit W
  function automatic q_arith_pkg::q_result_t q_mul(input q_arith_pkg::q_word_t a,
                                                   input q_arith_pkg::q_word_t c);
    longint                 exact;
    longint                 scaled;
    longint                 upper;
    q_arith_pkg::q_result_t r;
    exact      = longint'(a) * longint'(c);
    scaled     = exact >>> Q_BITS;
    upper      = scaled >>> W;
    r.value    = scaled[W-1:0];
    r.overflow = (upper != 0) && (upper != -1);
    return r;
  endfunction

  // One accumulator step with wrap-around and a sticky flag
  function automatic q_arith_pkg::q_result_t acc_step(input q_arith_pkg::q_result_t acc,
                                                      input q_arith_pkg::q_result_t p,
                                                      input biquad_pkg::acc_op_t op);
    int                     exact;
    q_arith_pkg::q_result_t r;
    if (op == biquad_pkg::ACC_LOAD) begin
      r = p;
    end else begin
      if (op == biquad_pkg::ACC_ADD) begin
        exact = int'($signed(acc.value)) + int'($signed(p.value));
      end else begin
        exact = int'($signed(acc.value)) - int'($signed(p.value));
      end
      r.value    = exact[W-1:0];
      r.overflow = acc.overflow || p.overflow || (exact > WORD_MAX) || (exact < WORD_MIN);
    end
    return r;
  endfunction

  // y = b0*x + b1*x1 + b2*x2 - a1*y1 - a2*y2, in the hardware's tap order
  function automatic q_arith_pkg::q_result_t model_output(input q_arith_pkg::q_word_t xin);
    q_arith_pkg::q_result_t r;
    r = q_mul(xin, active_coef.b0);
    r = acc_step(r, q_mul(hist_x1, active_coef.b1), biquad_pkg::ACC_ADD);
    r = acc_step(r, q_mul(hist_x2, active_coef.b2), biquad_pkg::ACC_ADD);
    r = acc_step(r, q_mul(hist_y1, active_coef.a1), biquad_pkg::ACC_SUB);
    r = acc_step(r, q_mul(hist_y2, active_coef.a2), biquad_pkg::ACC_SUB);
    return r;
  endfunction

  // Xorshift generator that advances the shared state and returns a signed word
  function automatic int random_word();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return int'($signed(rng_state[W-1:0]));
  endfunction

  //////////////////////////////
  // Driver and checks
  //////////////////////////////

  task automatic check_value(input string sig, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAILED t=%0t %s: expected %0h, got %0h", $time, sig, expected, actual);
      test_errors++;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n   <= 1'b0;
    coef_wr <= 1'b0;
    x_valid <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n   <= 1'b1;
    active_coef = '0;
    hist_x1 = '0;
    hist_x2 = '0;
    hist_y1 = '0;
    hist_y2 = '0;
  endtask

  task automatic write_coef(input biquad_pkg::biquad_coef_t c);
    @(posedge clk);
    coef_wr <= 1'b1;
    coef    <= c;
    @(posedge clk);
    coef_wr <= 1'b0;
    active_coef = c;
  endtask

  // Sends one sample and checks y, overflow, busy and latency
  // A nonzero inject_at pulses x_valid again that many cycles into the computation
  task automatic run_sample(input q_arith_pkg::q_word_t xin, input int inject_at);
    q_arith_pkg::q_result_t expected;
    int                     cycles;
    expected = model_output(xin);
    cycles   = 0;
    @(posedge clk);
    x_valid <= 1'b1;
    x       <= xin;
    while (!timed_out) begin
      @(posedge clk);
      if (inject_at > 0 && cycles == inject_at) begin
        x_valid <= 1'b1;
        x       <= ~xin;
      end else begin
        x_valid <= 1'b0;
      end
      @(negedge clk);
      cycles++;
      // The section stays busy from the first issue through the result cycle
      check_value("busy", 1, busy);
      if (y_valid) break;
      if (cycles >= TIMEOUT) begin
        $display("Timeout: no y_valid within %0d cycles in test %s", TIMEOUT, test_name);
        timed_out = 1'b1;
        test_errors++;
      end
    end
    if (!timed_out) begin
      check_value("latency", LATENCY, cycles);
      check_value("y", expected.value, y);
      check_value("overflow", expected.overflow, overflow);
      hist_x2 = hist_x1;
      hist_x1 = xin;
      hist_y2 = hist_y1;
      hist_y1 = expected.value;
    end
  endtask

  task automatic watch_quiet(input int n);
    repeat (n) begin
      @(negedge clk);
      assert (!y_valid) else begin
        $display("Unexpected extra y_valid pulse at t=%0t in test %s", $time, test_name);
        test_errors++;
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("PASS  %s", test_name);
    end else begin
      tests_failed++;
      $display("FAIL  %s with %0d errors", test_name, test_errors);
    end
  endtask

  task automatic fill_table();
    row_name[0] = "unity b0";
    row_coef[0] = make_coef(ONE, 0, 0, 0, 0);
    row_x[0]    = {16'sd1000, -16'sd2000, 16'sd16383, -16'sd16384,
                   16'sd5, 16'sd0, 16'sd32767, -16'sd32768};
    row_name[1] = "delay b1";
    row_coef[1] = make_coef(0, ONE, 0, 0, 0);
    row_x[1]    = {16'sd300, -16'sd700, 16'sd1200, 16'sd0,
                   -16'sd5, 16'sd9999, 16'sd42, -16'sd1};
    row_name[2] = "delay b2";
    row_coef[2] = make_coef(0, 0, ONE, 0, 0);
    row_x[2]    = {16'sd321, 16'sd4000, -16'sd4000, 16'sd77,
                   16'sd0, -16'sd123, 16'sd8, 16'sd0};
    // Impulse through a pole at 0.5 halves on every sample
    row_name[3] = "feedback a1";
    row_coef[3] = make_coef(ONE, 0, 0, -ONE / 2, 0);
    row_x[3]    = {16'sd8192, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0};
    // A full-scale negative sample times -2.0 carries into the sign bits
    // The b1 tap repeats it one sample later and the third sample is clean
    row_name[4] = "product overflow";
    row_coef[4] = make_coef(WORD_MIN, WORD_MIN, 0, 0, 0);
    row_x[4]    = {-16'sd32768, 16'sd100, 16'sd0, -16'sd32768,
                   16'sd50, -16'sd3, 16'sd20000, 16'sd0};
    // Two taps of 1.0 push the sum past full scale and wrap
    row_name[5] = "sum wrap";
    row_coef[5] = make_coef(ONE, ONE, 0, 0, 0);
    row_x[5]    = {16'sd20000, 16'sd20000, 16'sd0, 16'sd0,
                   -16'sd20000, -16'sd20000, 16'sd0, 16'sd1};
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int r;
    int i;
    clk          = 1'b0;
    rst_n        = 1'b0;
    coef_wr      = 1'b0;
    coef         = '0;
    x_valid      = 1'b0;
    x            = '0;
    rng_state    = 32'hd37f;
    timed_out    = 1'b0;
    tests_run    = 0;
    tests_failed = 0;
    fill_table();

    // Outputs come out of reset cleared
    start_test("reset values");
    apply_reset();
    @(negedge clk);
    check_value("y_valid", 0, y_valid);
    check_value("busy", 0, busy);
    check_value("overflow", 0, overflow);
    check_value("y", 0, y);
    finish_test();

    for (r = 0; r < NUM_ROWS && !timed_out; r++) begin
      start_test(row_name[r]);
      apply_reset();
      write_coef(row_coef[r]);
      for (i = 0; i < ROW_LEN && !timed_out; i++) begin
        run_sample(row_x[r][ROW_LEN-1-i], 0);
      end
      finish_test();
    end

    // A sample offered while busy must be dropped so the next output shows the old history
    if (!timed_out) begin
      start_test("x_valid while busy");
      apply_reset();
      write_coef(make_coef(ONE, ONE / 2, 0, 0, 0));
      run_sample(16'sd1000, 3);
      watch_quiet(10);
      if (!timed_out) begin
        run_sample(16'sd0, 0);
      end
      finish_test();
    end

    if (!timed_out) begin
      start_test("random row");
      apply_reset();
      write_coef(make_coef(random_word() >>> 1, random_word() >>> 1, random_word() >>> 1,
                           random_word() >>> 1, random_word() >>> 1));
      for (i = 0; i < RANDOM_LEN && !timed_out; i++) begin
        run_sample(random_word(), 0);
      end
      finish_test();
    end

    $display("Tests run: %0d, passed: %0d, failed: %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0 && !timed_out) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
